// ==== include/l2_params.svh ====
`ifndef L2_PARAMS_SVH
`define L2_PARAMS_SVH

// Line geometry
`define L2_LINE_BYTES 64

// Backing store depth in lines, addresses fold modulo this
`define L2_MEM_LINES 256
`define L2_MEM_IDX_W $clog2(`L2_MEM_LINES)

// Duplicated L1 data cache tags
`define L1_SETS 32
`define L1_WAYS 4

// Line address as seen on the PCI
`define L2_ADDR_W 26

`endif

// ==== l2_cache_model.f ====
+incdir+include
rtl/l2_pkg.sv
rtl/l2_request_stage.sv
rtl/l1_tag_directory.sv
rtl/l2_line_store.sv
rtl/l2_response_stage.sv
rtl/l2_cache_model.sv
testbench/tb_l2_cache_model.sv

// ==== rtl/l1_tag_directory.sv ====
`timescale 1ns/10ps
`include "l2_params.svh"

module l1_tag_directory
(
	input  logic            clk,
	input  logic            rst_n_i,
	input  logic            lookup_en_i,
	input  l2_pkg::l1_set_t lookup_set_i,
	input  l2_pkg::l1_tag_t lookup_tag_i,
	input  logic            fill_en_i,
	input  l2_pkg::way_t    fill_way_i,
	input  logic            inval_en_i,
	output logic            hit_o,
	output l2_pkg::way_t    hit_way_o
);

	logic [`L1_WAYS-1:0] valid_q [0:`L1_SETS-1];
	l2_pkg::l1_tag_t tag_q [0:`L1_SETS-1][0:`L1_WAYS-1];
	logic [`L1_WAYS-1:0] match;
	l2_pkg::way_t match_way;

	// All ways compared at once against the current array
	always_comb
	begin
		match = '0;
		match_way = '0;
		for (int w = 0; w < `L1_WAYS; w++)
			match[w] = valid_q[lookup_set_i][w] && tag_q[lookup_set_i][w] == lookup_tag_i;

		// Lowest matching way wins
		for (int w = `L1_WAYS - 1; w >= 0; w--)
		begin
			if (match[w])
				match_way = l2_pkg::way_t'(w);
		end
	end

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			for (int s = 0; s < `L1_SETS; s++)
				valid_q[s] <= '0;
			hit_o     <= 1'b0;
			hit_way_o <= '0;
		end
		else
		begin
			hit_o     <= lookup_en_i && |match;
			hit_way_o <= match_way;

			if (inval_en_i)
			begin
				for (int w = 0; w < `L1_WAYS; w++)
				begin
					if (match[w])
						valid_q[lookup_set_i][w] <= 1'b0;
				end
			end

			if (fill_en_i)
				valid_q[lookup_set_i][fill_way_i] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (fill_en_i)
			tag_q[lookup_set_i][fill_way_i] <= lookup_tag_i;
	end

endmodule

// ==== rtl/l2_cache_model.sv ====
`timescale 1ns/10ps
`include "l2_params.svh"

module l2_cache_model
(
	input  logic               clk,
	input  logic               rst_n_i,
	input  logic               pci_valid_i,
	input  l2_pkg::req_id_t    pci_id_i,
	input  l2_pkg::pci_op_t    pci_op_i,
	input  l2_pkg::way_t       pci_way_i,
	input  l2_pkg::line_addr_t pci_address_i,
	input  l2_pkg::line_t      pci_data_i,
	input  l2_pkg::byte_mask_t pci_mask_i,
	output logic               pci_ack_o,
	output logic               cpi_valid_o,
	output l2_pkg::req_id_t    cpi_id_o,
	output l2_pkg::cpi_op_t    cpi_op_o,
	output logic               cpi_allocate_o,
	output l2_pkg::way_t       cpi_way_o,
	output l2_pkg::line_t      cpi_data_o
);

	logic [`L2_MEM_IDX_W-1:0] rd_addr;
	logic wr_en;
	logic [`L2_MEM_IDX_W-1:0] wr_addr;
	l2_pkg::line_t wr_data;
	l2_pkg::byte_mask_t wr_mask;
	l2_pkg::line_t rd_line;
	logic lookup_en;
	l2_pkg::l1_set_t lookup_set;
	l2_pkg::l1_tag_t lookup_tag;
	logic fill_en;
	l2_pkg::way_t fill_way;
	logic inval_en;
	logic hit;
	l2_pkg::way_t hit_way;
	logic s1_valid;
	l2_pkg::req_id_t s1_id;
	l2_pkg::cpi_op_t s1_op;
	l2_pkg::way_t s1_way;
	logic s1_is_flush;

	l2_request_stage i_l2_request_stage
	(
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.pci_valid_i   (pci_valid_i),
		.pci_id_i      (pci_id_i),
		.pci_op_i      (pci_op_i),
		.pci_way_i     (pci_way_i),
		.pci_address_i (pci_address_i),
		.pci_data_i    (pci_data_i),
		.pci_mask_i    (pci_mask_i),
		.pci_ack_o     (pci_ack_o),
		.rd_addr_o     (rd_addr),
		.wr_en_o       (wr_en),
		.wr_addr_o     (wr_addr),
		.wr_data_o     (wr_data),
		.wr_mask_o     (wr_mask),
		.lookup_en_o   (lookup_en),
		.lookup_set_o  (lookup_set),
		.lookup_tag_o  (lookup_tag),
		.fill_en_o     (fill_en),
		.fill_way_o    (fill_way),
		.inval_en_o    (inval_en),
		.s1_valid_o    (s1_valid),
		.s1_id_o       (s1_id),
		.s1_op_o       (s1_op),
		.s1_way_o      (s1_way),
		.s1_is_flush_o (s1_is_flush)
	);

	l1_tag_directory i_l1_tag_directory
	(
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.lookup_en_i  (lookup_en),
		.lookup_set_i (lookup_set),
		.lookup_tag_i (lookup_tag),
		.fill_en_i    (fill_en),
		.fill_way_i   (fill_way),
		.inval_en_i   (inval_en),
		.hit_o        (hit),
		.hit_way_o    (hit_way)
	);

	l2_line_store i_l2_line_store
	(
		.clk       (clk),
		.rd_addr_i (rd_addr),
		.wr_en_i   (wr_en),
		.wr_addr_i (wr_addr),
		.wr_data_i (wr_data),
		.wr_mask_i (wr_mask),
		.rd_line_o (rd_line)
	);

	l2_response_stage i_l2_response_stage
	(
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.s1_valid_i     (s1_valid),
		.s1_id_i        (s1_id),
		.s1_op_i        (s1_op),
		.s1_way_i       (s1_way),
		.s1_is_flush_i  (s1_is_flush),
		.wr_data_i      (wr_data),
		.wr_mask_i      (wr_mask),
		.hit_i          (hit),
		.hit_way_i      (hit_way),
		.rd_line_i      (rd_line),
		.cpi_valid_o    (cpi_valid_o),
		.cpi_id_o       (cpi_id_o),
		.cpi_op_o       (cpi_op_o),
		.cpi_allocate_o (cpi_allocate_o),
		.cpi_way_o      (cpi_way_o),
		.cpi_data_o     (cpi_data_o)
	);

endmodule

// ==== rtl/l2_line_store.sv ====
`timescale 1ns/10ps
`include "l2_params.svh"

module l2_line_store
(
	input  logic                     clk,
	input  logic [`L2_MEM_IDX_W-1:0] rd_addr_i,
	input  logic                     wr_en_i,
	input  logic [`L2_MEM_IDX_W-1:0] wr_addr_i,
	input  l2_pkg::line_t            wr_data_i,
	input  l2_pkg::byte_mask_t       wr_mask_i,
	output l2_pkg::line_t            rd_line_o
);

	l2_pkg::line_t mem [0:`L2_MEM_LINES-1];
	l2_pkg::line_t old_line;
	l2_pkg::line_t merged_line;

	// Memory starts out all zero
	initial
	begin
		for (int i = 0; i < `L2_MEM_LINES; i++)
			mem[i] = '0;
	end

	assign old_line    = mem[wr_addr_i];
	assign merged_line = l2_pkg::merge_line(old_line, wr_data_i, wr_mask_i);

	always @(posedge clk)
	begin
		if (wr_en_i)
			mem[wr_addr_i] <= merged_line;
	end

	always_ff @(posedge clk)
	begin
		if (wr_en_i && wr_addr_i == rd_addr_i)
			rd_line_o <= merged_line; // Store in flight to the same line
		else
			rd_line_o <= mem[rd_addr_i];
	end

endmodule

// ==== rtl/l2_pkg.sv ====
`include "l2_params.svh"

package l2_pkg;

	typedef enum logic [1:0]
	{
		PCI_OP_LOAD       = 2'd0,
		PCI_OP_STORE      = 2'd1,
		PCI_OP_FLUSH      = 2'd2,
		PCI_OP_INVALIDATE = 2'd3
	} pci_op_t;

	typedef enum logic [1:0]
	{
		CPI_OP_LOAD           = 2'd0,
		CPI_OP_STORE          = 2'd1,
		CPI_OP_WRITE_VALIDATE = 2'd2, // Reserved, never issued
		CPI_OP_INVALIDATE     = 2'd3
	} cpi_op_t;

	localparam int SET_W = $clog2(`L1_SETS);

	typedef logic [`L2_LINE_BYTES*8-1:0] line_t;
	typedef logic [`L2_LINE_BYTES-1:0] byte_mask_t; // Bit n enables byte n
	typedef logic [`L2_ADDR_W-1:0] line_addr_t;
	typedef logic [`L2_ADDR_W-SET_W-1:0] l1_tag_t;
	typedef logic [SET_W-1:0] l1_set_t;
	typedef logic [$clog2(`L1_WAYS)-1:0] way_t;
	typedef logic [3:0] req_id_t; // Top two bits name the unit

	localparam logic [1:0] UNIT_L1D = 2'd1;

	// Byte-wise merge of a new line over an old one
	function automatic line_t merge_line(line_t old_line, line_t new_line, byte_mask_t mask);
		line_t merged;
		for (int b = 0; b < `L2_LINE_BYTES; b++)
			merged[b*8 +: 8] = mask[b] ? new_line[b*8 +: 8] : old_line[b*8 +: 8];
		return merged;
	endfunction

endpackage

// ==== rtl/l2_request_stage.sv ====
`timescale 1ns/10ps
`include "l2_params.svh"

module l2_request_stage
(
	input  logic                       clk,
	input  logic                       rst_n_i,
	input  logic                       pci_valid_i,
	input  l2_pkg::req_id_t            pci_id_i,
	input  l2_pkg::pci_op_t            pci_op_i,
	input  l2_pkg::way_t               pci_way_i,
	input  l2_pkg::line_addr_t         pci_address_i,
	input  l2_pkg::line_t              pci_data_i,
	input  l2_pkg::byte_mask_t         pci_mask_i,
	output logic                       pci_ack_o,
	output logic [`L2_MEM_IDX_W-1:0]   rd_addr_o,
	output logic                       wr_en_o,
	output logic [`L2_MEM_IDX_W-1:0]   wr_addr_o,
	output l2_pkg::line_t              wr_data_o,
	output l2_pkg::byte_mask_t         wr_mask_o,
	output logic                       lookup_en_o,
	output l2_pkg::l1_set_t            lookup_set_o,
	output l2_pkg::l1_tag_t            lookup_tag_o,
	output logic                       fill_en_o,
	output l2_pkg::way_t               fill_way_o,
	output logic                       inval_en_o,
	output logic                       s1_valid_o,
	output l2_pkg::req_id_t            s1_id_o,
	output l2_pkg::cpi_op_t            s1_op_o,
	output l2_pkg::way_t               s1_way_o,
	output logic                       s1_is_flush_o
);

	l2_pkg::cpi_op_t op_next;
	logic is_store;
	logic from_l1d;

	assign is_store = pci_op_i == l2_pkg::PCI_OP_STORE;
	assign from_l1d = pci_id_i[3:2] == l2_pkg::UNIT_L1D;

	// Flush is answered as a plain load
	always_comb
	begin
		case (pci_op_i)
			l2_pkg::PCI_OP_STORE:      op_next = l2_pkg::CPI_OP_STORE;
			l2_pkg::PCI_OP_INVALIDATE: op_next = l2_pkg::CPI_OP_INVALIDATE;
			default:                   op_next = l2_pkg::CPI_OP_LOAD;
		endcase
	end

	assign rd_addr_o = pci_address_i[`L2_MEM_IDX_W-1:0]; // Memory wraps

	// Directory side effects act on the incoming request
	assign lookup_en_o  = pci_valid_i;
	assign lookup_set_o = pci_address_i[l2_pkg::SET_W-1:0];
	assign lookup_tag_o = pci_address_i[`L2_ADDR_W-1:l2_pkg::SET_W];
	assign fill_en_o    = pci_valid_i && pci_op_i == l2_pkg::PCI_OP_LOAD && from_l1d;
	assign fill_way_o   = pci_way_i;
	assign inval_en_o   = pci_valid_i && pci_op_i == l2_pkg::PCI_OP_INVALIDATE;

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			pci_ack_o  <= 1'b0;
			s1_valid_o <= 1'b0;
			wr_en_o    <= 1'b0;
		end
		else
		begin
			pci_ack_o  <= pci_valid_i;
			s1_valid_o <= pci_valid_i;
			wr_en_o    <= pci_valid_i && is_store; // Store lands one cycle later
		end
	end

	always_ff @(posedge clk)
	begin
		if (pci_valid_i)
		begin
			s1_id_o       <= pci_id_i;
			s1_op_o       <= op_next;
			s1_way_o      <= pci_way_i;
			s1_is_flush_o <= pci_op_i == l2_pkg::PCI_OP_FLUSH;
			wr_addr_o     <= rd_addr_o;
			wr_data_o     <= pci_data_i;
			wr_mask_o     <= pci_mask_i;
		end
	end

endmodule

// ==== rtl/l2_response_stage.sv ====
`timescale 1ns/10ps

module l2_response_stage
(
	input  logic               clk,
	input  logic               rst_n_i,
	input  logic               s1_valid_i,
	input  l2_pkg::req_id_t    s1_id_i,
	input  l2_pkg::cpi_op_t    s1_op_i,
	input  l2_pkg::way_t       s1_way_i,
	input  logic               s1_is_flush_i,
	input  l2_pkg::line_t      wr_data_i,
	input  l2_pkg::byte_mask_t wr_mask_i,
	input  logic               hit_i,
	input  l2_pkg::way_t       hit_way_i,
	input  l2_pkg::line_t      rd_line_i,
	output logic               cpi_valid_o,
	output l2_pkg::req_id_t    cpi_id_o,
	output l2_pkg::cpi_op_t    cpi_op_o,
	output logic               cpi_allocate_o,
	output l2_pkg::way_t       cpi_way_o,
	output l2_pkg::line_t      cpi_data_o
);

	logic alloc_next;
	l2_pkg::way_t way_next;
	l2_pkg::line_t data_next;

	always_comb
	begin
		alloc_next = 1'b0;
		way_next = '0;
		data_next = '0;
		case (s1_op_i)
			l2_pkg::CPI_OP_LOAD:
			begin
				// Flush reads without allocating in the L1
				alloc_next = !s1_is_flush_i;
				way_next   = s1_is_flush_i ? '0 : s1_way_i;
				data_next  = rd_line_i;
			end
			l2_pkg::CPI_OP_STORE:
			begin
				alloc_next = hit_i; // Update only lines the L1 already holds
				way_next   = hit_i ? hit_way_i : '0;
				data_next  = l2_pkg::merge_line(rd_line_i, wr_data_i, wr_mask_i);
			end
			l2_pkg::CPI_OP_WRITE_VALIDATE,
			l2_pkg::CPI_OP_INVALIDATE:
				data_next = '0;
			default:
				data_next = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			cpi_valid_o    <= 1'b0;
			cpi_allocate_o <= 1'b0;
		end
		else
		begin
			cpi_valid_o    <= s1_valid_i;
			cpi_allocate_o <= s1_valid_i && alloc_next;
		end
	end

	always_ff @(posedge clk)
	begin
		cpi_id_o   <= s1_id_i;
		cpi_op_o   <= s1_op_i;
		cpi_way_o  <= way_next;
		cpi_data_o <= data_next;
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the L2 cache model testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_l2_cache_model -Mdir obj_dir \
	-f l2_cache_model.f -o sim_l2_cache_model \
	&& ./obj_dir/sim_l2_cache_model > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^\*\*\* TEST PASSED \*\*\*$" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
exit 0

// ==== testbench/tb_l2_cache_model.sv ====
`timescale 1ns/10ps
`include "l2_params.svh"

module tb_l2_cache_model;

	localparam int NUM_RANDOM = 400;
	localparam int NUM_DIRECTED = 24;
	localparam int TIMEOUT_NS = (NUM_RANDOM + NUM_DIRECTED) * 20 + 2000;

	typedef struct packed
	{
		logic [31:0]     due; // Cycle in which the response must show up
		l2_pkg::req_id_t id;
		l2_pkg::cpi_op_t op;
		logic            alloc;
		l2_pkg::way_t    way;
		l2_pkg::line_t   data;
	} resp_t;

	logic clk;
	logic rst_n_i;
	logic pci_valid_i;
	l2_pkg::req_id_t pci_id_i;
	l2_pkg::pci_op_t pci_op_i;
	l2_pkg::way_t pci_way_i;
	l2_pkg::line_addr_t pci_address_i;
	l2_pkg::line_t pci_data_i;
	l2_pkg::byte_mask_t pci_mask_i;
	logic pci_ack_o;
	logic cpi_valid_o;
	l2_pkg::req_id_t cpi_id_o;
	l2_pkg::cpi_op_t cpi_op_o;
	logic cpi_allocate_o;
	l2_pkg::way_t cpi_way_o;
	l2_pkg::line_t cpi_data_o;

	// Reference state
	l2_pkg::line_t mem_model [0:`L2_MEM_LINES-1];
	logic dir_valid [0:`L1_SETS-1][0:`L1_WAYS-1];
	l2_pkg::l1_tag_t dir_tag [0:`L1_SETS-1][0:`L1_WAYS-1];
	resp_t exp_q [$];
	l2_pkg::line_addr_t addr_pool [0:7];
	logic [31:0] rng_state;
	logic ack_expected;
	int cycle_count;
	int request_count;
	int check_count;
	int error_count;

	l2_cache_model i_l2_cache_model
	(
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.pci_valid_i    (pci_valid_i),
		.pci_id_i       (pci_id_i),
		.pci_op_i       (pci_op_i),
		.pci_way_i      (pci_way_i),
		.pci_address_i  (pci_address_i),
		.pci_data_i     (pci_data_i),
		.pci_mask_i     (pci_mask_i),
		.pci_ack_o      (pci_ack_o),
		.cpi_valid_o    (cpi_valid_o),
		.cpi_id_o       (cpi_id_o),
		.cpi_op_o       (cpi_op_o),
		.cpi_allocate_o (cpi_allocate_o),
		.cpi_way_o      (cpi_way_o),
		.cpi_data_o     (cpi_data_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic l2_pkg::line_t random_line();
		l2_pkg::line_t l;
		for (int i = 0; i < `L2_LINE_BYTES / 4; i++)
			l[i*32 +: 32] = next_random();
		return l;
	endfunction

	// Expand the byte mask to bits and blend
	function automatic l2_pkg::line_t apply_mask(l2_pkg::line_t old_line, l2_pkg::line_t new_line,
		l2_pkg::byte_mask_t mask);
		l2_pkg::line_t bit_sel;
		for (int b = 0; b < `L2_LINE_BYTES; b++)
			bit_sel[b*8 +: 8] = {8{mask[b]}};
		return (new_line & bit_sel) | (old_line & ~bit_sel);
	endfunction

	function automatic int find_way(int set, l2_pkg::l1_tag_t tag);
		for (int w = 0; w < `L1_WAYS; w++)
		begin
			if (dir_valid[set][w] && dir_tag[set][w] == tag)
				return w; // Lowest way first
		end
		return -1;
	endfunction

	task automatic report_mismatch(input string name, input logic [511:0] expected,
		input logic [511:0] actual);
		$display("[ERROR] %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
		error_count++;
	endtask

	task automatic model_request(input l2_pkg::req_id_t id, input l2_pkg::pci_op_t op,
		input l2_pkg::way_t way, input l2_pkg::line_addr_t addr, input l2_pkg::line_t data,
		input l2_pkg::byte_mask_t mask);
		resp_t r;
		int idx;
		int set;
		int hit_way;
		l2_pkg::l1_tag_t tag;
		idx = int'(addr % `L2_MEM_LINES);
		set = int'(addr % `L1_SETS);
		tag = l2_pkg::l1_tag_t'(addr / `L1_SETS);
		hit_way = find_way(set, tag);
		r.due = 32'(cycle_count + 2);
		r.id = id;
		r.op = l2_pkg::CPI_OP_LOAD;
		r.alloc = 1'b0;
		r.way = '0;
		r.data = '0;
		case (op)
			l2_pkg::PCI_OP_LOAD:
			begin
				r.alloc = 1'b1;
				r.way = way;
				r.data = mem_model[idx];
				if (id[3:2] == l2_pkg::UNIT_L1D)
				begin
					dir_valid[set][way] = 1'b1;
					dir_tag[set][way] = tag;
				end
			end
			l2_pkg::PCI_OP_STORE:
			begin
				r.op = l2_pkg::CPI_OP_STORE;
				r.data = apply_mask(mem_model[idx], data, mask);
				mem_model[idx] = r.data;
				if (hit_way >= 0)
				begin
					r.alloc = 1'b1;
					r.way = l2_pkg::way_t'(hit_way);
				end
			end
			l2_pkg::PCI_OP_FLUSH:
				r.data = mem_model[idx];
			default:
			begin
				r.op = l2_pkg::CPI_OP_INVALIDATE;
				for (int w = 0; w < `L1_WAYS; w++)
				begin
					if (dir_valid[set][w] && dir_tag[set][w] == tag)
						dir_valid[set][w] = 1'b0;
				end
			end
		endcase
		exp_q.push_back(r);
	endtask

	task automatic check_outputs();
		resp_t e;
		check_count++;
		if (pci_ack_o !== ack_expected)
			report_mismatch("pci_ack_o", 512'(ack_expected), 512'(pci_ack_o));
		if (exp_q.size() > 0 && exp_q[0].due == 32'(cycle_count))
		begin
			e = exp_q.pop_front();
			if (cpi_valid_o !== 1'b1)
				report_mismatch("cpi_valid_o", 512'(1), 512'(cpi_valid_o));
			if (cpi_id_o !== e.id)
				report_mismatch("cpi_id_o", 512'(e.id), 512'(cpi_id_o));
			if (cpi_op_o !== e.op)
				report_mismatch("cpi_op_o", 512'(e.op), 512'(cpi_op_o));
			if (cpi_allocate_o !== e.alloc)
				report_mismatch("cpi_allocate_o", 512'(e.alloc), 512'(cpi_allocate_o));
			if (cpi_way_o !== e.way)
				report_mismatch("cpi_way_o", 512'(e.way), 512'(cpi_way_o));
			if (cpi_data_o !== e.data)
				report_mismatch("cpi_data_o", e.data, cpi_data_o);
		end
		else
		begin
			if (cpi_valid_o !== 1'b0)
				report_mismatch("cpi_valid_o", 512'(0), 512'(cpi_valid_o));
			if (cpi_allocate_o !== 1'b0)
				report_mismatch("cpi_allocate_o", 512'(0), 512'(cpi_allocate_o));
		end
	endtask

	// Check the previous cycles' results, then drive the next slot
	task automatic drive_cycle(input logic valid, input l2_pkg::req_id_t id,
		input l2_pkg::pci_op_t op, input l2_pkg::way_t way, input l2_pkg::line_addr_t addr,
		input l2_pkg::line_t data, input l2_pkg::byte_mask_t mask);
		@(negedge clk);
		check_outputs();
		pci_valid_i = valid;
		pci_id_i = id;
		pci_op_i = op;
		pci_way_i = way;
		pci_address_i = addr;
		pci_data_i = data;
		pci_mask_i = mask;
		ack_expected = valid;
		if (valid)
		begin
			model_request(id, op, way, addr, data, mask);
			request_count++;
		end
		cycle_count++;
	endtask

	task automatic idle_cycle();
		drive_cycle(1'b0, '0, l2_pkg::PCI_OP_LOAD, '0, '0, '0, '0);
	endtask

	task automatic send_request(input l2_pkg::req_id_t id, input l2_pkg::pci_op_t op,
		input l2_pkg::way_t way, input l2_pkg::line_addr_t addr);
		l2_pkg::byte_mask_t mask;
		mask = {next_random(), next_random()};
		drive_cycle(1'b1, id, op, way, addr, random_line(), mask);
	endtask

	task automatic random_requests(input int count);
		logic [31:0] r;
		l2_pkg::req_id_t id;
		l2_pkg::byte_mask_t mask;
		for (int n = 0; n < count; n++)
		begin
			r = next_random();
			id = {r[24] ? l2_pkg::UNIT_L1D : r[13:12], r[15:14]}; // Lean towards L1D
			mask = (r[23:21] == 3'd0) ? '1 : {next_random(), next_random()};
			if (r[2:0] == 3'd0)
				idle_cycle();
			else
				drive_cycle(1'b1, id, l2_pkg::pci_op_t'(r[9:8]), r[17:16], addr_pool[r[20:18]],
					random_line(), mask);
		end
	endtask

	initial
	begin
		logic [31:0] r32;
		rst_n_i = 1'b0;
		pci_valid_i = 1'b0;
		pci_id_i = '0;
		pci_op_i = l2_pkg::PCI_OP_LOAD;
		pci_way_i = '0;
		pci_address_i = '0;
		pci_data_i = '0;
		pci_mask_i = '0;
		ack_expected = 1'b0;
		cycle_count = 0;
		request_count = 0;
		check_count = 0;
		error_count = 0;
		rng_state = 32'd80932;
		for (int i = 0; i < `L2_MEM_LINES; i++)
			mem_model[i] = '0;
		for (int s = 0; s < `L1_SETS; s++)
		begin
			for (int w = 0; w < `L1_WAYS; w++)
			begin
				dir_valid[s][w] = 1'b0;
				dir_tag[s][w] = '0;
			end
		end
		// Pairs i and i+4 share a set and a memory line but differ in tag
		for (int i = 0; i < 8; i++)
		begin
			r32 = next_random();
			addr_pool[i] = {r32[17:0], 6'd0, 2'(i % 4)};
		end

		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n_i = 1'b1;

		repeat (5) idle_cycle();
		send_request({l2_pkg::UNIT_L1D, 2'd1}, l2_pkg::PCI_OP_LOAD, 2'd2, addr_pool[0]);
		send_request({l2_pkg::UNIT_L1D, 2'd2}, l2_pkg::PCI_OP_STORE, 2'd0, addr_pool[0]);
		send_request(4'h8, l2_pkg::PCI_OP_LOAD, 2'd1, addr_pool[0]); // Right behind the store
		send_request(4'h9, l2_pkg::PCI_OP_FLUSH, 2'd3, addr_pool[0]);
		send_request({l2_pkg::UNIT_L1D, 2'd3}, l2_pkg::PCI_OP_STORE, 2'd0, addr_pool[4]);
		send_request(4'h0, l2_pkg::PCI_OP_LOAD, 2'd0, addr_pool[0]);
		send_request({l2_pkg::UNIT_L1D, 2'd0}, l2_pkg::PCI_OP_INVALIDATE, 2'd0, addr_pool[0]);
		idle_cycle();
		send_request({l2_pkg::UNIT_L1D, 2'd1}, l2_pkg::PCI_OP_STORE, 2'd0, addr_pool[0]);
		send_request(4'h3, l2_pkg::PCI_OP_LOAD, 2'd1, addr_pool[1]); // No fill from unit 0
		send_request(4'hc, l2_pkg::PCI_OP_STORE, 2'd0, addr_pool[1]);
		repeat (2) idle_cycle();

		random_requests(NUM_RANDOM);
		repeat (3) idle_cycle();

		if (exp_q.size() != 0)
		begin
			$display("Error: %0d expected responses were never seen", exp_q.size());
			error_count++;
		end
		$display("Requests %0d, checks %0d, errors %0d", request_count, check_count, error_count);
		if (error_count == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("Timeout: the test did not finish within %0d ns", TIMEOUT_NS);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule
